/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  wire xlen_t   a,
    input  wire xlen_t   b,
    input  wire alu_op_e op,
    output xlen_t        y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // rv32 shift amount

    always_comb
    begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_SLL:    y = a << shamt;
            ALU_SLT:    y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   y = {31'b0, a < b};
            ALU_XOR:    y = a ^ b;
            ALU_SRL:    y = a >> shamt;
            ALU_SRA:    y = xlen_t'($signed(a) >>> shamt);   // sign fill
            ALU_OR:     y = a | b;
            ALU_AND:    y = a & b;
            ALU_PASS_B: y = b;   // lui
            default:    y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* bsu.sv */
`timescale 1ns/1ps
`default_nettype none

module bsu import core_pkg::*; (
    input  wire xlen_t    rs1,
    input  wire xlen_t    rs2,
    input  wire br_type_e br_type,
    output logic          taken
);

    always_comb
    begin
        case (br_type)
            BR_EQ:   taken = (rs1 == rs2);
            BR_NE:   taken = (rs1 != rs2);
            BR_LT:   taken = ($signed(rs1) < $signed(rs2));
            BR_GE:   taken = ($signed(rs1) >= $signed(rs2));
            BR_LTU:  taken = (rs1 < rs2);
            BR_GEU:  taken = (rs1 >= rs2);
            default: taken = 1'b0;   // not a branch
        endcase
    end

endmodule

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] xlen_t;       // data / address word
    typedef logic [4:0]  reg_addr_t;   // x0..x31
    typedef logic [11:0] csr_addr_t;   // csr space index

    localparam xlen_t RESET_PC    = 32'h0000_0000;
    localparam int    DMEM_WORDS  = 256;
    localparam int    DMEM_AW     = $clog2(DMEM_WORDS);   // word index bits
    localparam xlen_t ECALL_CAUSE = 32'd11;               // ecall from m-mode

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    localparam logic [11:0] F12_ECALL = 12'h000;   // funct12 of ecall
    localparam logic [11:0] F12_MRET  = 12'h302;   // funct12 of mret

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {F3_PRIV = 3'b000, F3_CSRRW = 3'b001, F3_CSRRS = 3'b010} sys_f3_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_type_e;
    typedef enum logic       {A_PC = 1'b0, A_RS1 = 1'b1} a_sel_e;
    typedef enum logic [1:0] {B_RS2, B_CSR, B_ZERO, B_IMM} b_sel_e;
    typedef enum logic [2:0] {WB_NONE, WB_PC4, WB_ALU, WB_MEM, WB_CSR} wb_sel_e;
    typedef enum logic [1:0] {MEM_BYTE = 2'b00, MEM_HALF = 2'b01, MEM_WORD = 2'b10} mem_size_e;

    typedef struct packed {
        a_sel_e    a_sel;
        b_sel_e    b_sel;
        alu_op_e   alu_op;
        br_type_e  br_type;
        wb_sel_e   wb_sel;
        logic      reg_we;
        logic      mem_rd;
        logic      mem_wr;
        mem_size_e mem_size;
        logic      mem_unsigned;   // lbu / lhu
        logic      jump;           // jal / jalr
        logic      csr_we;
        logic      is_ecall;
        logic      is_mret;
    } ctrl_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire xlen_t inst,
    output xlen_t      pc,
    output wb_t        wb
);

    ctrl_t ctrl;
    xlen_t imm;
    xlen_t rs1_data, rs2_data;
    xlen_t alu_a, alu_b, alu_out;
    xlen_t mem_rdata, csr_rdata, trap_pc;
    xlen_t pc_plus4, next_pc, wb_data;
    logic  taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        if (ctrl.is_ecall || ctrl.is_mret)
            next_pc = trap_pc;                  // trap entry / return
        else if (ctrl.jump || taken)
            next_pc = alu_out & ~32'd1;         // jalr needs bit 0 cleared
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc <= RESET_PC;
        else
            pc <= next_pc;
    end

    assign alu_a = (ctrl.a_sel == A_RS1) ? rs1_data : pc;

    always_comb
    begin
        case (ctrl.b_sel)
            B_RS2:   alu_b = rs2_data;
            B_CSR:   alu_b = csr_rdata;   // csrrs set bits
            B_ZERO:  alu_b = '0;          // csrrw passes rs1
            default: alu_b = imm;
        endcase
    end

    always_comb
    begin
        case (ctrl.wb_sel)
            WB_PC4:  wb_data = pc_plus4;   // link address
            WB_ALU:  wb_data = alu_out;
            WB_MEM:  wb_data = mem_rdata;
            WB_CSR:  wb_data = csr_rdata;  // old csr value
            default: wb_data = '0;
        endcase
    end

    // retire record, held off while in reset
    assign wb = '{en: ctrl.reg_we & rst_n, rd: inst[11:7], data: wb_data};

    idu idu0 (.inst(inst), .ctrl(ctrl), .imm(imm));

    regfile regfile0 (
        .clk      (clk),
        .rs1_addr (inst[19:15]),
        .rs2_addr (inst[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    alu alu0 (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .y(alu_out));

    bsu bsu0 (.rs1(rs1_data), .rs2(rs2_data), .br_type(ctrl.br_type), .taken(taken));

    csr csr0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (inst[31:20]),
        .wdata   (alu_out),
        .we      (ctrl.csr_we),
        .ecall   (ctrl.is_ecall),
        .mret    (ctrl.is_mret),
        .pc      (pc),
        .rdata   (csr_rdata),
        .trap_pc (trap_pc)
    );

    data_mem data_mem0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd          (ctrl.mem_rd),
        .wr          (ctrl.mem_wr),
        .size        (ctrl.mem_size),
        .is_unsigned (ctrl.mem_unsigned),
        .addr        (alu_out),   // rs1 + imm
        .wdata       (rs2_data),
        .rdata       (mem_rdata)
    );

endmodule

`default_nettype wire

/* csr.sv */
`timescale 1ns/1ps
`default_nettype none

module csr import core_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire csr_addr_t addr,
    input  wire xlen_t     wdata,
    input  wire            we,
    input  wire            ecall,
    input  wire            mret,
    input  wire xlen_t     pc,
    output xlen_t          rdata,
    output xlen_t          trap_pc
);

    xlen_t mstatus;   // storage only, no mie/mpie behavior
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end
        else
        begin
            if (we)
            begin
                case (addr)
                    CSR_MSTATUS: mstatus <= wdata;
                    CSR_MTVEC:   mtvec   <= wdata;
                    CSR_MEPC:    mepc    <= wdata;
                    CSR_MCAUSE:  mcause  <= wdata;
                    default: ;
                endcase
            end
            if (ecall)
            begin
                mepc   <= pc;   // pc of the ecall itself
                mcause <= ECALL_CAUSE;
            end
        end
    end

    always_comb
    begin
        case (addr)
            CSR_MSTATUS: rdata = mstatus;
            CSR_MTVEC:   rdata = mtvec;
            CSR_MEPC:    rdata = mepc;
            CSR_MCAUSE:  rdata = mcause;
            default:     rdata = '0;
        endcase
    end

    assign trap_pc = mret ? mepc : mtvec;   // return vs. handler entry

    // decoder must never flag both system ops on one instruction
    assert property (@(posedge clk) disable iff (!rst_n) !(ecall && mret))
        else $error("ecall and mret asserted together");

endmodule

`default_nettype wire

/* data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem import core_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            rd,
    input  wire            wr,
    input  wire mem_size_e size,
    input  wire            is_unsigned,
    input  wire xlen_t     addr,
    input  wire xlen_t     wdata,
    output xlen_t          rdata
);

    xlen_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic [3:0]         be;           // byte lane enables
    logic [1:0]         align_mask;   // low addr bits that must be zero
    xlen_t              wdata_lane;
    xlen_t              shifted;

    assign idx = addr[DMEM_AW+1:2];   // upper bits ignored, wraps

    always_comb
    begin
        case (size)
            MEM_BYTE:
            begin
                be         = 4'b0001 << addr[1:0];
                wdata_lane = {4{wdata[7:0]}};
                align_mask = 2'b00;
            end
            MEM_HALF:
            begin
                be         = 4'b0011 << addr[1:0];
                wdata_lane = {2{wdata[15:0]}};
                align_mask = 2'b01;
            end
            default:
            begin
                be         = 4'b1111;
                wdata_lane = wdata;
                align_mask = 2'b11;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (wr && rst_n)   // no stores while in reset
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (be[i])
                    mem[idx][8*i +: 8] <= wdata_lane[8*i +: 8];
            end
        end
    end

    assign shifted = mem[idx] >> {addr[1:0], 3'b000};   // addressed lane to bit 0

    always_comb
    begin
        case (size)
            MEM_BYTE: rdata = is_unsigned ? {24'b0, shifted[7:0]}
                                          : {{24{shifted[7]}}, shifted[7:0]};
            MEM_HALF: rdata = is_unsigned ? {16'b0, shifted[15:0]}
                                          : {{16{shifted[15]}}, shifted[15:0]};
            default:  rdata = shifted;
        endcase
        if (!rd)
            rdata = '0;
    end

    // address from the alu must match the decoded access size
    assert property (@(posedge clk) disable iff (!rst_n)
                     (rd || wr) |-> ((addr[1:0] & align_mask) == 2'b00))
        else $error("misaligned data access at %h", addr);

endmodule

`default_nettype wire

/* idu.sv */
`timescale 1ns/1ps
`default_nettype none

module idu import core_pkg::*; (
    input  wire xlen_t inst,
    output ctrl_t      ctrl,
    output xlen_t      imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;   // funct7[5], sub / sra select

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    // funct3 to alu op, shared by op and op-imm
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_sra);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl              = '0;
        ctrl.a_sel        = A_RS1;
        ctrl.b_sel        = B_IMM;
        ctrl.alu_op       = ALU_ADD;
        ctrl.br_type      = BR_NONE;
        ctrl.wb_sel       = WB_NONE;
        ctrl.mem_size     = mem_size_e'(funct3[1:0]);   // lb/lh/lw, sb/sh/sw
        ctrl.mem_unsigned = funct3[2];
        imm               = {{20{inst[31]}}, inst[31:20]};   // i-type default
        case (opcode)
            OP_LUI:
            begin
                imm         = {inst[31:12], 12'b0};
                ctrl.alu_op = ALU_PASS_B;
                ctrl.wb_sel = WB_ALU;
                ctrl.reg_we = 1'b1;
            end
            OP_AUIPC:
            begin
                imm         = {inst[31:12], 12'b0};
                ctrl.a_sel  = A_PC;
                ctrl.wb_sel = WB_ALU;
                ctrl.reg_we = 1'b1;
            end
            OP_JAL:
            begin
                imm         = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                ctrl.a_sel  = A_PC;   // target = pc + imm
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.reg_we = 1'b1;
            end
            OP_JALR:
            begin
                ctrl.jump   = 1'b1;   // target = rs1 + imm
                ctrl.wb_sel = WB_PC4;
                ctrl.reg_we = 1'b1;
            end
            OP_BRANCH:
            begin
                imm        = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                ctrl.a_sel = A_PC;
                case (funct3)
                    3'b000:  ctrl.br_type = BR_EQ;
                    3'b001:  ctrl.br_type = BR_NE;
                    3'b100:  ctrl.br_type = BR_LT;
                    3'b101:  ctrl.br_type = BR_GE;
                    3'b110:  ctrl.br_type = BR_LTU;
                    3'b111:  ctrl.br_type = BR_GEU;
                    default: ctrl.br_type = BR_NONE;
                endcase
            end
            OP_LOAD:
            begin
                ctrl.mem_rd = 1'b1;
                ctrl.wb_sel = WB_MEM;
                ctrl.reg_we = 1'b1;
            end
            OP_STORE:
            begin
                imm         = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                ctrl.mem_wr = 1'b1;
            end
            OP_IMM:
            begin
                ctrl.alu_op = alu_from_f3(funct3, (funct3 == 3'b101) && alt);   // no subi
                ctrl.wb_sel = WB_ALU;
                ctrl.reg_we = 1'b1;
            end
            OP_REG:
            begin
                ctrl.b_sel  = B_RS2;
                ctrl.alu_op = alu_from_f3(funct3, alt);
                ctrl.wb_sel = WB_ALU;
                ctrl.reg_we = 1'b1;
            end
            OP_SYSTEM:
            begin
                case (sys_f3_e'(funct3))
                    F3_PRIV:
                    begin
                        ctrl.is_ecall = (inst[31:20] == F12_ECALL);
                        ctrl.is_mret  = (inst[31:20] == F12_MRET);
                    end
                    F3_CSRRW:
                    begin
                        ctrl.b_sel  = B_ZERO;   // rs1 + 0 passes rs1
                        ctrl.csr_we = 1'b1;
                        ctrl.wb_sel = WB_CSR;
                        ctrl.reg_we = 1'b1;
                    end
                    F3_CSRRS:
                    begin
                        ctrl.b_sel  = B_CSR;    // rs1 | csr
                        ctrl.alu_op = ALU_OR;
                        ctrl.csr_we = 1'b1;
                        ctrl.wb_sel = WB_CSR;
                        ctrl.reg_we = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;   // fence and unknown opcodes act as nop
        endcase
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
core_pkg.sv
idu.sv
regfile.sv
alu.sv
bsu.sv
csr.sv
data_mem.sv
core_top.sv
tb_core.sv

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
    input  wire            clk,
    input  wire reg_addr_t rs1_addr,
    input  wire reg_addr_t rs2_addr,
    output xlen_t          rs1_data,
    output xlen_t          rs2_data,
    input  wire wb_t       wb
);

    xlen_t rf [32];

    assign rs1_data = (rs1_addr == '0) ? '0 : rf[rs1_addr];   // x0 hardwired
    assign rs2_data = (rs2_addr == '0) ? '0 : rf[rs2_addr];

    always_ff @(posedge clk)
    begin
        if (wb.en && wb.rd != '0)   // x0 writes dropped
            rf[wb.rd] <= wb.data;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_core -o tb_core
./obj_dir/tb_core | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation log is clean"

/* tb_prog.svh */
// columns: pc, instruction word, expected wb.en, rd, wb data, next pc
task automatic load_program();
    // upper immediates and op-imm
    add_entry(32'h000, enc_u(20'h12345, 5'd1, OP_LUI), 1'b1, 5'd1, 32'h1234_5000, 32'h004);
    add_entry(32'h004, enc_i(12'h678, 5'd1, 3'b000, 5'd1, OP_IMM), 1'b1, 5'd1, 32'h1234_5678, 32'h008);
    add_entry(32'h008, enc_u(20'h00001, 5'd2, OP_AUIPC), 1'b1, 5'd2, 32'h0000_1008, 32'h00c);
    add_entry(32'h00c, enc_i(12'hffb, 5'd0, 3'b000, 5'd3, OP_IMM), 1'b1, 5'd3, 32'hffff_fffb, 32'h010);
    add_entry(32'h010, enc_i(12'h001, 5'd3, 3'b010, 5'd4, OP_IMM), 1'b1, 5'd4, 32'h1, 32'h014);
    add_entry(32'h014, enc_i(12'h001, 5'd3, 3'b011, 5'd4, OP_IMM), 1'b1, 5'd4, 32'h0, 32'h018);
    add_entry(32'h018, enc_i(12'h0ff, 5'd1, 3'b100, 5'd5, OP_IMM), 1'b1, 5'd5, 32'h1234_5687, 32'h01c);
    add_entry(32'h01c, enc_i(12'h0f0, 5'd1, 3'b111, 5'd5, OP_IMM), 1'b1, 5'd5, 32'h70, 32'h020);
    add_entry(32'h020, enc_i(12'h004, 5'd1, 3'b001, 5'd6, OP_IMM), 1'b1, 5'd6, 32'h2345_6780, 32'h024);
    add_entry(32'h024, enc_i(12'h01c, 5'd3, 3'b101, 5'd7, OP_IMM), 1'b1, 5'd7, 32'hf, 32'h028);
    add_entry(32'h028, enc_i(12'h401, 5'd3, 3'b101, 5'd8, OP_IMM), 1'b1, 5'd8, 32'hffff_fffd, 32'h02c);
    // register-register
    add_entry(32'h02c, enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd9), 1'b1, 5'd9, 32'h1234_5673, 32'h030);
    add_entry(32'h030, enc_r(7'h20, 5'd3, 5'd1, 3'b000, 5'd10), 1'b1, 5'd10, 32'h1234_567d, 32'h034);
    add_entry(32'h034, enc_r(7'h20, 5'd7, 5'd3, 3'b101, 5'd11), 1'b1, 5'd11, 32'hffff_ffff, 32'h038);
    add_entry(32'h038, enc_r(7'h00, 5'd7, 5'd1, 3'b101, 5'd12), 1'b1, 5'd12, 32'h2468, 32'h03c);
    add_entry(32'h03c, enc_r(7'h00, 5'd1, 5'd3, 3'b010, 5'd13), 1'b1, 5'd13, 32'h1, 32'h040);
    add_entry(32'h040, enc_r(7'h00, 5'd1, 5'd3, 3'b011, 5'd14), 1'b1, 5'd14, 32'h0, 32'h044);
    add_entry(32'h044, enc_r(7'h00, 5'd3, 5'd1, 3'b100, 5'd15), 1'b1, 5'd15, 32'hedcb_a983, 32'h048);
    add_entry(32'h048, enc_r(7'h00, 5'd7, 5'd5, 3'b110, 5'd16), 1'b1, 5'd16, 32'h7f, 32'h04c);
    add_entry(32'h04c, enc_r(7'h00, 5'd3, 5'd1, 3'b111, 5'd17), 1'b1, 5'd17, 32'h1234_5678, 32'h050);
    add_entry(32'h050, enc_r(7'h00, 5'd7, 5'd7, 3'b001, 5'd18), 1'b1, 5'd18, 32'h0007_8000, 32'h054);
    // x0 write shows on wb, then x0 still reads zero
    add_entry(32'h054, enc_i(12'h005, 5'd1, 3'b000, 5'd0, OP_IMM), 1'b1, 5'd0, 32'h1234_567d, 32'h058);
    add_entry(32'h058, enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd19), 1'b1, 5'd19, 32'h1234_5678, 32'h05c);
    // branch pairs, not taken then taken over one unused word
    add_entry(32'h05c, enc_b(13'd8, 5'd3, 5'd1, 3'b000), 1'b0, 5'd0, 32'h0, 32'h060);
    add_entry(32'h060, enc_b(13'd8, 5'd19, 5'd1, 3'b000), 1'b0, 5'd0, 32'h0, 32'h068);
    add_entry(32'h068, enc_b(13'd8, 5'd19, 5'd1, 3'b001), 1'b0, 5'd0, 32'h0, 32'h06c);
    add_entry(32'h06c, enc_b(13'd8, 5'd3, 5'd1, 3'b001), 1'b0, 5'd0, 32'h0, 32'h074);
    add_entry(32'h074, enc_b(13'd8, 5'd3, 5'd1, 3'b100), 1'b0, 5'd0, 32'h0, 32'h078);
    add_entry(32'h078, enc_b(13'd8, 5'd1, 5'd3, 3'b100), 1'b0, 5'd0, 32'h0, 32'h080);
    add_entry(32'h080, enc_b(13'd8, 5'd1, 5'd3, 3'b101), 1'b0, 5'd0, 32'h0, 32'h084);
    add_entry(32'h084, enc_b(13'd8, 5'd3, 5'd1, 3'b101), 1'b0, 5'd0, 32'h0, 32'h08c);
    add_entry(32'h08c, enc_b(13'd8, 5'd1, 5'd3, 3'b110), 1'b0, 5'd0, 32'h0, 32'h090);
    add_entry(32'h090, enc_b(13'd8, 5'd3, 5'd1, 3'b110), 1'b0, 5'd0, 32'h0, 32'h098);
    add_entry(32'h098, enc_b(13'd8, 5'd3, 5'd1, 3'b111), 1'b0, 5'd0, 32'h0, 32'h09c);
    add_entry(32'h09c, enc_b(13'd8, 5'd1, 5'd3, 3'b111), 1'b0, 5'd0, 32'h0, 32'h0a4);
    // stores build 0xfffbfb78 at 0x104, then loads
    add_entry(32'h0a4, enc_i(12'h100, 5'd0, 3'b000, 5'd20, OP_IMM), 1'b1, 5'd20, 32'h100, 32'h0a8);
    add_entry(32'h0a8, enc_s(12'h000, 5'd1, 5'd20, 3'b010), 1'b0, 5'd0, 32'h0, 32'h0ac);
    add_entry(32'h0ac, enc_s(12'h004, 5'd1, 5'd20, 3'b000), 1'b0, 5'd0, 32'h0, 32'h0b0);
    add_entry(32'h0b0, enc_s(12'h005, 5'd3, 5'd20, 3'b000), 1'b0, 5'd0, 32'h0, 32'h0b4);
    add_entry(32'h0b4, enc_s(12'h006, 5'd3, 5'd20, 3'b001), 1'b0, 5'd0, 32'h0, 32'h0b8);
    add_entry(32'h0b8, enc_i(12'h005, 5'd20, 3'b000, 5'd21, OP_LOAD), 1'b1, 5'd21, 32'hffff_fffb, 32'h0bc);
    add_entry(32'h0bc, enc_i(12'h005, 5'd20, 3'b100, 5'd22, OP_LOAD), 1'b1, 5'd22, 32'h0000_00fb, 32'h0c0);
    add_entry(32'h0c0, enc_i(12'h004, 5'd20, 3'b001, 5'd23, OP_LOAD), 1'b1, 5'd23, 32'hffff_fb78, 32'h0c4);
    add_entry(32'h0c4, enc_i(12'h004, 5'd20, 3'b101, 5'd24, OP_LOAD), 1'b1, 5'd24, 32'h0000_fb78, 32'h0c8);
    add_entry(32'h0c8, enc_i(12'h000, 5'd20, 3'b010, 5'd25, OP_LOAD), 1'b1, 5'd25, 32'h1234_5678, 32'h0cc);
    add_entry(32'h0cc, enc_i(12'h004, 5'd20, 3'b010, 5'd26, OP_LOAD), 1'b1, 5'd26, 32'hfffb_fb78, 32'h0d0);
    // jal, then jalr to an odd target
    add_entry(32'h0d0, enc_j(21'd8, 5'd27), 1'b1, 5'd27, 32'h0d4, 32'h0d8);
    add_entry(32'h0d8, enc_i(12'h0e5, 5'd0, 3'b000, 5'd28, OP_IMM), 1'b1, 5'd28, 32'h0e5, 32'h0dc);
    add_entry(32'h0dc, enc_i(12'h000, 5'd28, 3'b000, 5'd29, OP_JALR), 1'b1, 5'd29, 32'h0e0, 32'h0e4);
    // trap round trip through a handler at 0x200
    add_entry(32'h0e4, enc_i(12'h200, 5'd0, 3'b000, 5'd30, OP_IMM), 1'b1, 5'd30, 32'h200, 32'h0e8);
    add_entry(32'h0e8, enc_i(CSR_MTVEC, 5'd30, 3'b001, 5'd0, OP_SYSTEM), 1'b1, 5'd0, 32'h0, 32'h0ec);
    add_entry(32'h0ec, enc_i(12'h000, 5'd0, 3'b000, 5'd0, OP_SYSTEM), 1'b0, 5'd0, 32'h0, 32'h200);
    add_entry(32'h200, enc_i(CSR_MEPC, 5'd0, 3'b010, 5'd5, OP_SYSTEM), 1'b1, 5'd5, 32'h0ec, 32'h204);
    add_entry(32'h204, enc_i(CSR_MCAUSE, 5'd0, 3'b010, 5'd6, OP_SYSTEM), 1'b1, 5'd6, 32'd11, 32'h208);
    add_entry(32'h208, enc_i(12'h004, 5'd5, 3'b000, 5'd5, OP_IMM), 1'b1, 5'd5, 32'h0f0, 32'h20c);
    add_entry(32'h20c, enc_i(CSR_MEPC, 5'd5, 3'b001, 5'd0, OP_SYSTEM), 1'b1, 5'd0, 32'h0ec, 32'h210);
    add_entry(32'h210, enc_i(12'h302, 5'd0, 3'b000, 5'd0, OP_SYSTEM), 1'b0, 5'd0, 32'h0, 32'h0f0);
    add_entry(32'h0f0, enc_j(21'd0, 5'd0), 1'b1, 5'd0, 32'h0f4, 32'h0f0);   // end, spins here
endtask

/* tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam int    ROM_WORDS = 256;
    localparam xlen_t DONE_PC   = 32'h0000_00f0;   // closing self loop

    logic      clk;
    logic      rst_n;
    xlen_t     inst;
    xlen_t     pc;
    wb_t       wb;

    xlen_t     rom       [ROM_WORDS];
    logic      exp_valid [ROM_WORDS];   // address holds a program entry
    logic      exp_en    [ROM_WORDS];
    reg_addr_t exp_rd    [ROM_WORDS];
    xlen_t     exp_data  [ROM_WORDS];
    xlen_t     exp_next  [ROM_WORDS];

    logic [7:0] pidx;
    logic       cur_valid;
    logic       cur_en;
    reg_addr_t  cur_rd;
    xlen_t      cur_data;
    xlen_t      prev_next;   // next pc owed by the last retired instruction
    logic       prev_run;
    int         cycles = 0;
    int         limit;
    int         n_entries;
    int         wb_errors;
    int         pc_errors;
    int         run_errors;

    assign pidx      = pc[9:2];
    assign inst      = rom[pidx];   // rom model, combinational fetch
    assign cur_valid = exp_valid[pidx];
    assign cur_en    = exp_en[pidx];
    assign cur_rd    = exp_rd[pidx];
    assign cur_data  = exp_data[pidx];

    core_top dut0 (.clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .wb(wb));

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic xlen_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic xlen_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic xlen_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic xlen_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic xlen_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic add_entry(input xlen_t addr, input xlen_t word, input logic en,
                             input reg_addr_t rd, input xlen_t data, input xlen_t next);
        rom[addr[9:2]]       = word;
        exp_valid[addr[9:2]] = 1'b1;
        exp_en[addr[9:2]]    = en;
        exp_rd[addr[9:2]]    = rd;
        exp_data[addr[9:2]]  = data;
        exp_next[addr[9:2]]  = next;
        n_entries++;
    endtask

    task automatic fill_rom();
        logic [11:0] junk;
        for (int i = 0; i < ROM_WORDS; i++)
        begin
            junk              = 12'($urandom);
            rom[i[7:0]]       = enc_i(junk, 5'd0, 3'b000, 5'd0, OP_IMM);   // addi x0, x0, junk
            exp_valid[i[7:0]] = 1'b0;
        end
    endtask

    `include "tb_prog.svh"

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    always @(posedge clk)
    begin
        cycles    <= cycles + 1;
        prev_next <= exp_next[pidx];
        prev_run  <= rst_n;
    end

    assert property (@(posedge clk) !rst_n |-> (pc == RESET_PC && !wb.en))
        else begin
            pc_errors++;
            $display("error: reset pc/en expected %h/0 actual %h/%b",
                     RESET_PC, $sampled(pc), $sampled(wb.en));
        end

    assert property (@(posedge clk) $rose(rst_n) |-> pc == RESET_PC)
        else begin
            pc_errors++;
            $display("error: first_fetch expected %h actual %h", RESET_PC, $sampled(pc));
        end

    assert property (@(posedge clk) disable iff (!rst_n) cur_valid)
        else begin
            pc_errors++;
            $display("pc %h is outside the test program", $sampled(pc));
        end

    assert property (@(posedge clk) disable iff (!rst_n) wb.en == cur_en)
        else begin
            wb_errors++;
            $display("error: wb_en at pc %h expected %b actual %b",
                     $sampled(pc), $sampled(cur_en), $sampled(wb.en));
        end

    assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> wb.rd == cur_rd)
        else begin
            wb_errors++;
            $display("error: wb_rd at pc %h expected %0d actual %0d",
                     $sampled(pc), $sampled(cur_rd), $sampled(wb.rd));
        end

    assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> wb.data == cur_data)
        else begin
            wb_errors++;
            $display("error: wb_data at pc %h expected %h actual %h",
                     $sampled(pc), $sampled(cur_data), $sampled(wb.data));
        end

    assert property (@(posedge clk) disable iff (!rst_n) prev_run |-> pc == prev_next)
        else begin
            pc_errors++;
            $display("error: next_pc expected %h actual %h", $sampled(prev_next), $sampled(pc));
        end

    initial
    begin
        void'($urandom(32'h212e));
        rst_n      = 1'b1;
        prev_run   = 1'b0;
        prev_next  = '0;
        n_entries  = 0;
        wb_errors  = 0;
        pc_errors  = 0;
        run_errors = 0;
        fill_rom();
        load_program();
        limit = 4 * n_entries + 50;
        #1 rst_n = 1'b0;   // clean falling edge for the async reset
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (pc != DONE_PC && cycles < limit);
        if (pc != DONE_PC)
        begin
            run_errors++;
            $display("timeout, pc %h did not reach the end of the program in %0d cycles",
                     pc, limit);
        end
        repeat (2) @(posedge clk);   // self loop retires twice more
        #1;
        $display("errors: wb %0d, pc %0d, run %0d", wb_errors, pc_errors, run_errors);
        if (wb_errors + pc_errors + run_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
